// File: Bender.yml
package:
  name: axil_reg_file

sources:
  - design/axil_reg_pkg.sv
  - design/axil_write_ctrl.sv
  - design/axil_read_ctrl.sv
  - design/axil_reg_bank.sv
  - design/axil_reg_file.sv
  - target: test
    files:
      - test/axil_reg_checker.sv
      - test/tb_axil_reg_file.sv

// File: design/axil_read_ctrl.sv
`timescale 1ns/1ps

module axil_read_ctrl (
    input  logic                      ACLK,
    input  logic                      ARESET,
    // AR channel
    input  axil_reg_pkg::axil_addr_t  ar_addr,
    input  logic                      ar_valid,
    output logic                      ar_ready,
    // R channel
    output axil_reg_pkg::axil_r_t     r,
    output logic                      r_valid,
    input  logic                      r_ready,
    // Bank read port
    output axil_reg_pkg::reg_idx_t    rd_idx,
    input  axil_reg_pkg::axil_data_t  rd_data
);
    import axil_reg_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,      // Waiting for an address
        ST_LOOKUP,    // Bank output settles on the latched index
        ST_DATA       // Holding read data
    } rd_state_t;

    rd_state_t  state, state_nxt;
    reg_idx_t   ar_idx;
    logic       ar_hs;
    logic       r_hs;

    assign ar_hs = ar_valid & ar_ready;
    assign r_hs  = r_valid & r_ready;

    assign ar_ready = (state == ST_IDLE);
    assign r_valid  = (state == ST_DATA);
    assign rd_idx   = ar_idx;

    always_comb begin
        state_nxt = state;
        unique case (state)
            ST_IDLE:   if (ar_hs) state_nxt = ST_LOOKUP;
            ST_LOOKUP: state_nxt = ST_DATA;    // Always one cycle
            ST_DATA:   if (r_hs) state_nxt = ST_IDLE;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Index and read data payload
    always_ff @(posedge ACLK) begin
        if (ar_hs) begin
            ar_idx <= ar_addr[AXIL_ADDR_W-1 -: REG_IDX_W];
        end
        if (state == ST_LOOKUP) begin
            r.data <= rd_data;      // Snapshot of the word
            r.resp <= RESP_OKAY;
        end
    end

    // Stalled R beat must not change
    assert property (@(posedge ACLK) disable iff (ARESET)
        r_valid && !r_ready |=> r_valid && $stable(r));

endmodule

// File: design/axil_reg_bank.sv
`timescale 1ns/1ps

module axil_reg_bank (
    input  logic                      ACLK,
    input  logic                      ARESET,
    // Write command
    input  axil_reg_pkg::reg_wr_t     wr,
    input  logic                      wr_en,
    // Read port
    input  axil_reg_pkg::reg_idx_t    rd_idx,
    output axil_reg_pkg::axil_data_t  rd_data
);
    import axil_reg_pkg::*;

    axil_data_t regs [REG_COUNT];    // The sixteen words
    axil_data_t merged;              // Addressed word with new bytes applied

    // Strobe merge
    // Bytes without a strobe keep the stored value
    always_comb begin
        merged = regs[wr.idx];
        for (int b = 0; b < AXIL_STRB_W; b++) begin
            if (wr.strb[b]) begin
                merged[8*b +: 8] = wr.data[8*b +: 8];
            end
        end
    end

    // Storage
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;    // All words clear
            end
        end else if (wr_en) begin
            regs[wr.idx] <= merged;
        end
    end

    // Read is a plain mux on current contents
    assign rd_data = regs[rd_idx];

endmodule

// File: design/axil_reg_file.sv
`timescale 1ns/1ps

module axil_reg_file (
    input  logic                      ACLK,
    input  logic                      ARESET,
    // AW channel
    input  axil_reg_pkg::axil_addr_t  aw_addr,
    input  logic                      aw_valid,
    output logic                      aw_ready,
    // W channel
    input  axil_reg_pkg::axil_w_t     w,
    input  logic                      w_valid,
    output logic                      w_ready,
    // B channel
    output axil_reg_pkg::axil_resp_t  b_resp,
    output logic                      b_valid,
    input  logic                      b_ready,
    // AR channel
    input  axil_reg_pkg::axil_addr_t  ar_addr,
    input  logic                      ar_valid,
    output logic                      ar_ready,
    // R channel
    output axil_reg_pkg::axil_r_t     r,
    output logic                      r_valid,
    input  logic                      r_ready
);
    import axil_reg_pkg::*;

    reg_wr_t    wr;         // Commit from write side
    logic       wr_en;
    reg_idx_t   rd_idx;     // Lookup from read side
    axil_data_t rd_data;

    // Write path
    axil_write_ctrl write_ctrl_i (
        .ACLK     (ACLK),
        .ARESET   (ARESET),
        .aw_addr  (aw_addr),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b_resp   (b_resp),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .wr       (wr),
        .wr_en    (wr_en)
    );

    // Read path runs alongside the write path
    axil_read_ctrl read_ctrl_i (
        .ACLK     (ACLK),
        .ARESET   (ARESET),
        .ar_addr  (ar_addr),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data)
    );

    axil_reg_bank reg_bank_i (
        .ACLK     (ACLK),
        .ARESET   (ARESET),
        .wr       (wr),
        .wr_en    (wr_en),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data)
    );

endmodule

// File: design/axil_reg_pkg.sv
package axil_reg_pkg;

    // Bus geometry
    localparam int AXIL_ADDR_W = 6;                  // Byte address into 16 words
    localparam int AXIL_DATA_W = 32;                 // One register word
    localparam int AXIL_STRB_W = AXIL_DATA_W / 8;    // One strobe per byte

    // Register bank geometry
    localparam int REG_COUNT = 16;
    localparam int REG_IDX_W = $clog2(REG_COUNT);    // Upper address bits

    // Basic field types
    typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [AXIL_DATA_W-1:0] axil_data_t;
    typedef logic [AXIL_STRB_W-1:0] axil_strb_t;
    typedef logic [1:0]             axil_resp_t;
    typedef logic [REG_IDX_W-1:0]   reg_idx_t;

    // Only OKAY is ever returned
    localparam axil_resp_t RESP_OKAY = 2'b00;

    // W channel payload
    typedef struct packed {
        axil_data_t data;    // Write data
        axil_strb_t strb;    // Byte enables
    } axil_w_t;

    // R channel payload
    typedef struct packed {
        axil_data_t data;    // Read data
        axil_resp_t resp;    // Read response
    } axil_r_t;

    // Write command from the write controller into the bank
    typedef struct packed {
        reg_idx_t   idx;     // Target word
        axil_data_t data;    // New bytes
        axil_strb_t strb;    // Which bytes to replace
    } reg_wr_t;

endpackage

// File: design/axil_write_ctrl.sv
`timescale 1ns/1ps

module axil_write_ctrl (
    input  logic                      ACLK,
    input  logic                      ARESET,
    // AW channel
    input  axil_reg_pkg::axil_addr_t  aw_addr,
    input  logic                      aw_valid,
    output logic                      aw_ready,
    // W channel
    input  axil_reg_pkg::axil_w_t     w,
    input  logic                      w_valid,
    output logic                      w_ready,
    // B channel
    output axil_reg_pkg::axil_resp_t  b_resp,
    output logic                      b_valid,
    input  logic                      b_ready,
    // Command into the register bank
    output axil_reg_pkg::reg_wr_t     wr,
    output logic                      wr_en
);
    import axil_reg_pkg::*;

    typedef enum logic {
        ST_IDLE,    // Collecting address and data
        ST_RESP     // Holding the write response
    } wr_state_t;

    wr_state_t  state, state_nxt;
    logic       aw_full;    // Address held
    logic       w_full;     // Data held
    reg_idx_t   aw_idx;     // Word index of the held address
    axil_w_t    w_hold;     // Held data and strobes
    logic       aw_hs;
    logic       w_hs;
    logic       b_hs;

    // Handshakes
    assign aw_hs = aw_valid & aw_ready;
    assign w_hs  = w_valid & w_ready;
    assign b_hs  = b_valid & b_ready;

    // Each side takes one beat and then waits for the other
    assign aw_ready = !aw_full && (state == ST_IDLE);
    assign w_ready  = !w_full && (state == ST_IDLE);

    // Both halves present so commit now
    assign wr_en = aw_full & w_full;

    assign wr.idx  = aw_idx;
    assign wr.data = w_hold.data;
    assign wr.strb = w_hold.strb;

    assign b_valid = (state == ST_RESP);
    assign b_resp  = RESP_OKAY;    // No error cases in this bank

    // Response FSM
    always_comb begin
        state_nxt = state;
        unique case (state)
            ST_IDLE: begin
                if (wr_en) begin
                    state_nxt = ST_RESP;    // b_valid follows the commit edge
                end
            end
            ST_RESP: begin
                if (b_hs) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Full flags are set by the handshake and cleared by the commit
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
        end else begin
            if (aw_hs) begin
                aw_full <= 1'b1;
            end else if (wr_en) begin
                aw_full <= 1'b0;
            end
            if (w_hs) begin
                w_full <= 1'b1;
            end else if (wr_en) begin
                w_full <= 1'b0;
            end
        end
    end

    // Holding registers
    always_ff @(posedge ACLK) begin
        if (aw_hs) begin
            aw_idx <= aw_addr[AXIL_ADDR_W-1 -: REG_IDX_W];    // Low two bits dropped
        end
        if (w_hs) begin
            w_hold <= w;
        end
    end

    // Response must stay up until the master takes it
    assert property (@(posedge ACLK) disable iff (ARESET)
        b_valid && !b_ready |=> b_valid);

    // A second commit cannot start while the last one is still unacknowledged
    assert property (@(posedge ACLK) disable iff (ARESET)
        b_valid |-> !wr_en);

endmodule

// File: test/axil_reg_checker.sv
`timescale 1ns/1ps

module axil_reg_checker (
    input  logic                      ACLK,
    input  logic                      ARESET,
    input  axil_reg_pkg::axil_addr_t  aw_addr,
    input  logic                      aw_valid,
    input  logic                      aw_ready,
    input  axil_reg_pkg::axil_w_t     w,
    input  logic                      w_valid,
    input  logic                      w_ready,
    input  axil_reg_pkg::axil_resp_t  b_resp,
    input  logic                      b_valid,
    input  logic                      b_ready,
    input  axil_reg_pkg::axil_addr_t  ar_addr,
    input  logic                      ar_valid,
    input  logic                      ar_ready,
    input  axil_reg_pkg::axil_r_t     r,
    input  logic                      r_valid,
    input  logic                      r_ready,
    output int                        errors,           // Mismatches and protocol faults
    output int                        reads_checked,    // R transfers compared
    output int                        writes_seen       // B transfers applied to the model
);
    import axil_reg_pkg::*;

    string      test_name = "idle";    // Set by the testbench per test
    axil_data_t model [REG_COUNT];     // Expected contents
    logic       aw_have, w_have;       // Halves of the write in flight
    reg_idx_t   pend_idx;
    axil_w_t    pend_w;
    reg_idx_t   rd_word;               // Index captured at AR
    axil_data_t exp_old, exp_new;      // Read may land on either side of a write
    logic       b_stalled, r_stalled;
    axil_r_t    r_prev;

    // Reference byte merge, old bytes survive where the strobe is clear
    function automatic axil_data_t merge_bytes(input axil_data_t old_word,
                                               input axil_data_t new_word,
                                               input axil_strb_t strb);
        axil_data_t mask;
        mask = '0;
        for (int i = 0; i < AXIL_STRB_W; i++) begin
            if (strb[i]) mask = mask | (axil_data_t'(32'hFF) << (8 * i));
        end
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    always @(posedge ACLK) begin
        if (ARESET) begin
            for (int i = 0; i < REG_COUNT; i++) model[i] = '0;
            aw_have = 1'b0;
            w_have = 1'b0;
            b_stalled = 1'b0;
            r_stalled = 1'b0;
            errors = 0;
            reads_checked = 0;
            writes_seen = 0;
        end else begin
            // Stalled responses must hold
            if (b_stalled && !b_valid) begin
                $display("Error in %s: b_valid dropped before b_ready", test_name);
                errors++;
            end
            if (r_stalled && (!r_valid || r !== r_prev)) begin
                $display("Error in %s: R beat changed while r_ready was low", test_name);
                errors++;
            end
            // No new address while a response is still out
            if (b_valid && (aw_ready || w_ready)) begin
                $display("Error in %s: write channel ready while b_valid is high", test_name);
                errors++;
            end
            if (r_valid && ar_ready) begin
                $display("Error in %s: ar_ready high while r_valid is high", test_name);
                errors++;
            end
            if (aw_valid && aw_ready) begin
                pend_idx = reg_idx_t'(aw_addr >> 2);    // Low two bits ignored
                aw_have = 1'b1;
            end
            if (w_valid && w_ready) begin
                pend_w = w;
                w_have = 1'b1;
            end
            if (b_valid && b_ready) begin    // Model follows the B transfer
                if (!(aw_have && w_have)) begin
                    $display("Error in %s: B response without a captured write", test_name);
                    errors++;
                end else begin
                    model[pend_idx] = merge_bytes(model[pend_idx], pend_w.data, pend_w.strb);
                end
                if (b_resp !== RESP_OKAY) begin
                    $display("Fail %s: b_resp expected %h actual %h",
                             test_name, RESP_OKAY, b_resp);
                    errors++;
                end
                aw_have = 1'b0;
                w_have = 1'b0;
                writes_seen++;
            end
            if (ar_valid && ar_ready) begin
                rd_word = reg_idx_t'(ar_addr >> 2);
                exp_old = model[rd_word];
                exp_new = exp_old;
                if (aw_have && w_have && pend_idx == rd_word)
                    exp_new = merge_bytes(exp_old, pend_w.data, pend_w.strb);
            end
            if (r_valid && r_ready) begin
                if (r.data !== exp_old && r.data !== exp_new) begin
                    if (exp_old === exp_new)
                        $display("Fail %s: word %0d expected %h actual %h",
                                 test_name, rd_word, exp_old, r.data);
                    else
                        $display("Fail %s: word %0d expected %h or %h actual %h",
                                 test_name, rd_word, exp_old, exp_new, r.data);
                    errors++;
                end
                if (r.resp !== RESP_OKAY) begin
                    $display("Fail %s: r.resp expected %h actual %h",
                             test_name, RESP_OKAY, r.resp);
                    errors++;
                end
                reads_checked++;
            end
            b_stalled = b_valid && !b_ready;
            r_stalled = r_valid && !r_ready;
            r_prev = r;
        end
    end

endmodule

// File: test/tb_axil_reg_file.sv
`timescale 1ns/1ps

module tb_axil_reg_file;
    import axil_reg_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 200;    // Cycles before a channel counts as stalled
    localparam int CH_AW = 0;
    localparam int CH_W  = 1;
    localparam int CH_B  = 2;
    localparam int CH_AR = 3;
    localparam int CH_R  = 4;

    logic       ACLK;
    logic       ARESET;
    axil_addr_t aw_addr;
    logic       aw_valid, aw_ready;
    axil_w_t    w;
    logic       w_valid, w_ready;
    axil_resp_t b_resp;
    logic       b_valid, b_ready;
    axil_addr_t ar_addr;
    logic       ar_valid, ar_ready;
    axil_r_t    r;
    logic       r_valid, r_ready;

    int checker_errors, reads_checked, writes_seen;
    int tb_errors, reads_issued, writes_issued;
    int max_stall;                       // Longest response back-pressure
    int unsigned seed;

    axil_reg_file dut_i (
        .ACLK(ACLK), .ARESET(ARESET),
        .aw_addr(aw_addr), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w(w), .w_valid(w_valid), .w_ready(w_ready),
        .b_resp(b_resp), .b_valid(b_valid), .b_ready(b_ready),
        .ar_addr(ar_addr), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .r(r), .r_valid(r_valid), .r_ready(r_ready)
    );

    axil_reg_checker chk_i (
        .ACLK(ACLK), .ARESET(ARESET),
        .aw_addr(aw_addr), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w(w), .w_valid(w_valid), .w_ready(w_ready),
        .b_resp(b_resp), .b_valid(b_valid), .b_ready(b_ready),
        .ar_addr(ar_addr), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .r(r), .r_valid(r_valid), .r_ready(r_ready),
        .errors(checker_errors), .reads_checked(reads_checked), .writes_seen(writes_seen)
    );

    always #5 ACLK = ~ACLK;    // 10 ns period

    // The side of each channel the testbench waits on
    function automatic logic level_of(input int ch);
        case (ch)
            CH_AW:   return aw_ready;
            CH_W:    return w_ready;
            CH_B:    return b_valid;
            CH_AR:   return ar_ready;
            default: return r_valid;
        endcase
    endfunction

    function automatic string channel_name(input int ch);
        case (ch)
            CH_AW:   return "AW";
            CH_W:    return "W";
            CH_B:    return "B";
            CH_AR:   return "AR";
            default: return "R";
        endcase
    endfunction

    function automatic axil_addr_t byte_addr(input int idx, input int unsigned low);
        return axil_addr_t'((idx % REG_COUNT) * 4 + (low % 4));
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge ACLK);
            #1;
        end
    endtask

    // Sample at the falling edge where everything is settled and transfer at the next rise
    task automatic wait_for(input int ch);
        int cycles;
        cycles = 0;
        @(negedge ACLK);
        while (!level_of(ch)) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout: %s channel made no transfer in %0d cycles",
                         channel_name(ch), WAIT_LIMIT);
                $display("*** FAILED ***");
                $finish;
            end
            @(negedge ACLK);
        end
        @(posedge ACLK);
        #1;
    endtask

    task automatic send_aw(input axil_addr_t addr);
        idle_cycles($urandom % 3);
        aw_addr = addr;
        aw_valid = 1'b1;
        wait_for(CH_AW);
        aw_valid = 1'b0;
    endtask

    task automatic send_w(input axil_data_t data, input axil_strb_t strb);
        idle_cycles($urandom % 3);
        w.data = data;
        w.strb = strb;
        w_valid = 1'b1;
        wait_for(CH_W);
        w_valid = 1'b0;
    endtask

    // Order 0 drives both together, 1 sends data first, 2 sends the address first
    task automatic write_word(input axil_addr_t addr, input axil_data_t data,
                              input axil_strb_t strb, input int order);
        case (order)
            0: fork
                send_aw(addr);
                send_w(data, strb);
            join
            1: begin
                send_w(data, strb);
                send_aw(addr);
            end
            default: begin
                send_aw(addr);
                send_w(data, strb);
            end
        endcase
        idle_cycles($urandom % (max_stall + 1));    // Response back-pressure
        b_ready = 1'b1;
        wait_for(CH_B);
        b_ready = 1'b0;
        writes_issued++;
    endtask

    task automatic read_word(input axil_addr_t addr);
        idle_cycles($urandom % 3);
        ar_addr = addr;
        ar_valid = 1'b1;
        wait_for(CH_AR);
        ar_valid = 1'b0;
        idle_cycles($urandom % (max_stall + 1));
        r_ready = 1'b1;
        wait_for(CH_R);
        r_ready = 1'b0;
        reads_issued++;
    endtask

    task automatic start_test(input string name);
        chk_i.test_name = name;
        $display("Running %s", name);
    endtask

    initial begin
        int idx;
        ACLK = 1'b0;
        ARESET = 1'b1;
        aw_addr = '0;
        aw_valid = 1'b0;
        w = '0;
        w_valid = 1'b0;
        b_ready = 1'b0;
        ar_addr = '0;
        ar_valid = 1'b0;
        r_ready = 1'b0;
        tb_errors = 0;
        reads_issued = 0;
        writes_issued = 0;
        max_stall = 3;
        seed = 32'h3845bfcf;
        void'($urandom(seed));
        repeat (RESET_CYCLES) @(posedge ACLK);
        #1;
        ARESET = 1'b0;

        start_test("reset_values");
        for (int i = 0; i < REG_COUNT; i++) read_word(byte_addr(i, 0));

        start_test("full_strobe");    // Unaligned low bits hit the same word
        for (int i = 0; i < REG_COUNT; i++)
            write_word(byte_addr(i, $urandom), $urandom, 4'hF, $urandom % 3);
        for (int i = 0; i < REG_COUNT; i++) read_word(byte_addr(i, $urandom));

        start_test("partial_strobe");
        repeat (32) write_word(byte_addr($urandom % REG_COUNT, $urandom), $urandom,
                               axil_strb_t'($urandom), $urandom % 3);
        for (int i = 0; i < REG_COUNT; i++) read_word(byte_addr(i, 0));

        start_test("write_order");
        for (int i = 0; i < 2 * REG_COUNT; i++) begin
            write_word(byte_addr(i, 0), $urandom, axil_strb_t'($urandom), 1 + (i % 2));
            read_word(byte_addr(i, 0));
        end

        start_test("back_pressure");
        max_stall = 12;
        repeat (16) begin
            write_word(byte_addr($urandom % REG_COUNT, 0), $urandom, 4'hF, $urandom % 3);
            read_word(byte_addr($urandom % REG_COUNT, 0));
        end
        max_stall = 3;

        start_test("overlap");    // Read races a write to the same word
        repeat (24) begin
            idx = $urandom % REG_COUNT;
            fork
                write_word(byte_addr(idx, $urandom), $urandom, axil_strb_t'($urandom),
                           $urandom % 3);
                begin
                    idle_cycles($urandom % 4);
                    read_word(byte_addr(idx, $urandom));
                end
            join
        end

        idle_cycles(4);
        if (reads_checked != reads_issued) begin
            $display("Checker compared %0d reads but %0d were issued", reads_checked,
                     reads_issued);
            tb_errors++;
        end
        if (writes_seen != writes_issued) begin
            $display("Checker saw %0d writes but %0d were issued", writes_seen, writes_issued);
            tb_errors++;
        end
        $display("Errors: %0d checker, %0d testbench over %0d writes and %0d reads",
                 checker_errors, tb_errors, writes_issued, reads_issued);
        if (checker_errors == 0 && tb_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog.f
design/axil_reg_pkg.sv
design/axil_write_ctrl.sv
design/axil_read_ctrl.sv
design/axil_reg_bank.sv
design/axil_reg_file.sv
test/axil_reg_checker.sv
test/tb_axil_reg_file.sv
